// File: verilog/eth_loopback_defs.svh
// Ethernet loopback constants
`ifndef ETH_LOOPBACK_DEFS_SVH
`define ETH_LOOPBACK_DEFS_SVH

// Frame lengths in bytes
`define ETH_MIN_FRAME_LEN 32'd60
`define ETH_MAX_FRAME_LEN 11'd1518

// Frame FIFO size in entries, a power of two
`define FIFO_DEPTH 2048

// Idle bytes between frames after reset
`define DEFAULT_IFG 8'd12

// Register map
`define REG_CFG       3'd0
`define REG_RX_GOOD   3'd1
`define REG_RX_BAD    3'd2
`define REG_RX_DROP   3'd3
`define REG_TX_FRAMES 3'd4

`endif

// File: verilog/eth_loopback_pkg.sv
// Ethernet loopback types
`default_nettype none

package eth_loopback_pkg;

// One byte of frame data on its way through the FIFO
typedef struct packed {
    logic [7:0] data;
    logic       last;
    logic       bad;
} eth_beat_t;

// Runtime configuration
typedef struct packed {
    logic [7:0] ifg;
    logic       rx_enable;
    logic       tx_enable;
} mac_cfg_t;

// Single-cycle event pulses for the counters
typedef struct packed {
    logic rx_good;
    logic rx_bad;
    logic rx_drop;
    logic tx_frame;
} mac_stat_t;

// CRC-32 over one byte, LSB first
// Reflected form of polynomial 0x04C11DB7
function automatic logic [31:0] crc32_step(
    input logic [31:0] crc,
    input logic [7:0]  data
);
    logic [31:0] c;

    c = crc ^ {24'd0, data};
    for (int i = 0; i < 8; i++) begin
        if (c[0]) begin
            c = (c >> 1) ^ 32'hEDB88320;
        end else begin
            c = c >> 1;
        end
    end
    return c;
endfunction

endpackage

`default_nettype wire

// File: verilog/gmii_rx_framer.sv
// GMII receive framer
`timescale 1ns/10ps
`default_nettype none

`include "eth_loopback_defs.svh"

module gmii_rx_framer (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic [7:0]                 rxd,
    input  wire logic                       rx_dv,
    input  wire logic                       rx_er,
    input  wire eth_loopback_pkg::mac_cfg_t cfg,
    output eth_loopback_pkg::eth_beat_t     beat,
    output logic                            beat_wr,
    output logic                            stat_good,
    output logic                            stat_bad
);

import eth_loopback_pkg::*;

// What the running CRC holds after a frame with a correct FCS
localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;

typedef enum logic [1:0] {ST_IDLE, ST_PRE, ST_DATA, ST_DROP} state_t;

state_t      state;
logic [7:0]  dly [4];
logic [7:0]  pend;
logic        pend_vld;
logic [10:0] cnt;
logic [31:0] crc;
logic        err;
logic        frame_bad;

// Verdict on the complete frame, FCS included in cnt
assign frame_bad = (crc != CRC_RESIDUE) || err
    || (cnt < 11'(`ETH_MIN_FRAME_LEN + 4)) || (cnt > `ETH_MAX_FRAME_LEN);

always_ff @(posedge clk) begin
    if (rst) begin
        state     <= ST_IDLE;
        beat_wr   <= 1'b0;
        stat_good <= 1'b0;
        stat_bad  <= 1'b0;
        pend_vld  <= 1'b0;
        cnt       <= '0;
        err       <= 1'b0;
    end else begin
        beat_wr   <= 1'b0;
        stat_good <= 1'b0;
        stat_bad  <= 1'b0;

        case (state)
            ST_IDLE: begin
                // Disabled receiver skips the whole frame
                if (rx_dv) begin
                    if (cfg.rx_enable && rxd == 8'h55) begin
                        state <= ST_PRE;
                    end else begin
                        state <= ST_DROP;
                    end
                end
            end
            ST_PRE: begin
                if (!rx_dv) begin
                    state <= ST_IDLE;
                end else if (rxd == 8'hD5) begin
                    crc      <= '1;
                    cnt      <= '0;
                    err      <= 1'b0;
                    pend_vld <= 1'b0;
                    state    <= ST_DATA;
                end else if (rxd != 8'h55) begin
                    state <= ST_DROP;
                end
            end
            ST_DATA: begin
                if (rx_dv) begin
                    dly[0] <= rxd;
                    dly[1] <= dly[0];
                    dly[2] <= dly[1];
                    dly[3] <= dly[2];
                    crc    <= crc32_step(crc, rxd);
                    if (cnt != '1) begin
                        cnt <= cnt + 11'd1;
                    end
                    if (rx_er) begin
                        err <= 1'b1;
                    end
                    // Byte leaving the delay line cannot be FCS any more
                    if (cnt >= 11'd4) begin
                        pend     <= dly[3];
                        pend_vld <= 1'b1;
                        if (pend_vld) begin
                            beat    <= '{data: pend, last: 1'b0, bad: 1'b0};
                            beat_wr <= 1'b1;
                        end
                    end
                end else begin
                    // End of frame, the held byte closes it
                    if (pend_vld) begin
                        beat    <= '{data: pend, last: 1'b1, bad: frame_bad};
                        beat_wr <= 1'b1;
                    end
                    stat_good <= !frame_bad;
                    stat_bad  <= frame_bad;
                    state     <= ST_IDLE;
                end
            end
            ST_DROP: begin
                if (!rx_dv) begin
                    state <= ST_IDLE;
                end
            end
            default: state <= ST_IDLE;
        endcase
    end
end

endmodule

`default_nettype wire

// File: verilog/frame_fifo.sv
// Store-and-forward frame FIFO
`timescale 1ns/10ps
`default_nettype none

module frame_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 2048
) (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire entry_t wr_data,
    input  wire logic   wr_en,
    input  wire logic   wr_last,
    input  wire logic   wr_bad,
    output entry_t      rd_data,
    input  wire logic   rd_en,
    output logic        frame_ready,
    output logic        drop
);

localparam int AW = $clog2(DEPTH);

entry_t      mem [DEPTH];
logic        last_mem [DEPTH];
logic [AW:0] wr_ptr;
logic [AW:0] wr_commit;
logic [AW:0] rd_ptr;
logic [AW:0] frame_cnt;
logic        ovf;
logic        full;
logic        empty;
logic        commit;
logic        pop_last;

// Extra pointer bit tells full from empty
assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
assign empty = (rd_ptr == wr_commit);

assign commit   = wr_en && wr_last && !wr_bad && !ovf && !full;
assign pop_last = rd_en && !empty && last_mem[rd_ptr[AW-1:0]];

// Head entry is always visible, no read latency
assign rd_data     = mem[rd_ptr[AW-1:0]];
assign frame_ready = (frame_cnt != '0);

always_ff @(posedge clk) begin
    if (wr_en && !full && !ovf) begin
        mem[wr_ptr[AW-1:0]]      <= wr_data;
        last_mem[wr_ptr[AW-1:0]] <= wr_last;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        wr_ptr    <= '0;
        wr_commit <= '0;
        rd_ptr    <= '0;
        frame_cnt <= '0;
        ovf       <= 1'b0;
        drop      <= 1'b0;
    end else begin
        drop <= 1'b0;

        if (wr_en) begin
            if (wr_last) begin
                if (commit) begin
                    wr_ptr    <= wr_ptr + 1'b1;
                    wr_commit <= wr_ptr + 1'b1;
                end else begin
                    // Bad or overflowed frame, forget its entries
                    wr_ptr <= wr_commit;
                    drop   <= ovf || full;
                end
                ovf <= 1'b0;
            end else if (full || ovf) begin
                ovf <= 1'b1;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end

        if (rd_en && !empty) begin
            rd_ptr <= rd_ptr + 1'b1;
        end

        if (commit && !pop_last) begin
            frame_cnt <= frame_cnt + 1'b1;
        end else if (pop_last && !commit) begin
            frame_cnt <= frame_cnt - 1'b1;
        end
    end
end

endmodule

`default_nettype wire

// File: verilog/gmii_tx_framer.sv
// GMII transmit framer
`timescale 1ns/10ps
`default_nettype none

`include "eth_loopback_defs.svh"

module gmii_tx_framer (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire eth_loopback_pkg::mac_cfg_t  cfg,
    input  wire logic                        frame_ready,
    input  wire eth_loopback_pkg::eth_beat_t beat,
    output logic                             beat_rd,
    output logic [7:0]                       txd,
    output logic                             tx_en,
    output wire logic                        tx_er,
    output logic                             stat_frame
);

import eth_loopback_pkg::*;

typedef enum logic [2:0] {
    ST_IDLE,
    ST_PRE,
    ST_DATA,
    ST_PAD,
    ST_FCS,
    ST_GAP
} state_t;

state_t      state;
logic [2:0]  cnt;
logic [10:0] len;
logic [10:0] len_next;
logic [31:0] crc;
logic [7:0]  gap_cnt;

assign len_next = len + 11'd1;

// One FIFO beat consumed per data cycle
assign beat_rd = (state == ST_DATA);

// Frames are never corrupted on purpose
assign tx_er = 1'b0;

always_ff @(posedge clk) begin
    if (rst) begin
        state      <= ST_IDLE;
        txd        <= 8'h00;
        tx_en      <= 1'b0;
        stat_frame <= 1'b0;
        cnt        <= '0;
        gap_cnt    <= '0;
    end else begin
        stat_frame <= 1'b0;

        case (state)
            ST_IDLE: begin
                if (frame_ready && cfg.tx_enable && gap_cnt == 8'd0) begin
                    tx_en <= 1'b1;
                    txd   <= 8'h55;
                    cnt   <= 3'd1;
                    state <= ST_PRE;
                end
            end
            ST_PRE: begin
                // Seven preamble bytes then the SFD
                if (cnt == 3'd7) begin
                    txd   <= 8'hD5;
                    crc   <= '1;
                    len   <= '0;
                    state <= ST_DATA;
                end else begin
                    txd <= 8'h55;
                    cnt <= cnt + 3'd1;
                end
            end
            ST_DATA: begin
                txd <= beat.data;
                crc <= crc32_step(crc, beat.data);
                len <= len_next;
                if (beat.last) begin
                    cnt <= '0;
                    if (len_next < 11'(`ETH_MIN_FRAME_LEN)) begin
                        state <= ST_PAD;
                    end else begin
                        state <= ST_FCS;
                    end
                end
            end
            ST_PAD: begin
                txd <= 8'h00;
                crc <= crc32_step(crc, 8'h00);
                len <= len_next;
                if (len_next == 11'(`ETH_MIN_FRAME_LEN)) begin
                    state <= ST_FCS;
                end
            end
            ST_FCS: begin
                // Inverted CRC, low byte first
                txd <= ~crc[8*cnt +: 8];
                cnt <= cnt + 3'd1;
                if (cnt == 3'd3) begin
                    stat_frame <= 1'b1;
                    gap_cnt    <= cfg.ifg;
                    state      <= ST_GAP;
                end
            end
            ST_GAP: begin
                // Entered on the last FCS byte, counts idle cycles after it
                tx_en <= 1'b0;
                txd   <= 8'h00;
                if (gap_cnt != 8'd0) begin
                    gap_cnt <= gap_cnt - 8'd1;
                end
                if (gap_cnt <= 8'd1) begin
                    state <= ST_IDLE;
                end
            end
            default: state <= ST_IDLE;
        endcase
    end
end

endmodule

`default_nettype wire

// File: verilog/mac_cfg_regs.sv
// MAC configuration and statistics registers
`timescale 1ns/10ps
`default_nettype none

`include "eth_loopback_defs.svh"

module mac_cfg_regs (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        reg_wr,
    input  wire logic                        reg_rd,
    input  wire logic [2:0]                  reg_addr,
    input  wire logic [31:0]                 reg_wdata,
    output logic [31:0]                      reg_rdata,
    input  wire eth_loopback_pkg::mac_stat_t stat,
    output eth_loopback_pkg::mac_cfg_t       cfg,
    output wire logic [1:0]                  led
);

// Counter index to register address
localparam logic [2:0] CNT_ADDR [4] = '{
    `REG_RX_GOOD,
    `REG_RX_BAD,
    `REG_RX_DROP,
    `REG_TX_FRAMES
};

logic [31:0] cnt [4];
logic [3:0]  ev;
logic        led_tx;

assign ev  = {stat.tx_frame, stat.rx_drop, stat.rx_bad, stat.rx_good};
assign led = {led_tx, cfg.rx_enable};

always_ff @(posedge clk) begin
    if (rst) begin
        cfg       <= '{ifg: `DEFAULT_IFG, rx_enable: 1'b1, tx_enable: 1'b1};
        led_tx    <= 1'b0;
        reg_rdata <= '0;
        for (int i = 0; i < 4; i++) begin
            cnt[i] <= '0;
        end
    end else begin
        // CFG layout is ifg in [7:0], rx_enable in bit 8, tx_enable in bit 9
        if (reg_wr && reg_addr == `REG_CFG) begin
            cfg.ifg       <= reg_wdata[7:0];
            cfg.rx_enable <= reg_wdata[8];
            cfg.tx_enable <= reg_wdata[9];
        end

        if (stat.tx_frame) begin
            led_tx <= !led_tx;
        end

        // Any write clears, otherwise count and stick at all ones
        for (int i = 0; i < 4; i++) begin
            if (reg_wr && reg_addr == CNT_ADDR[i]) begin
                cnt[i] <= '0;
            end else if (ev[i] && cnt[i] != '1) begin
                cnt[i] <= cnt[i] + 32'd1;
            end
        end

        if (reg_rd) begin
            case (reg_addr)
                `REG_CFG:       reg_rdata <= {22'd0, cfg.tx_enable, cfg.rx_enable, cfg.ifg};
                `REG_RX_GOOD:   reg_rdata <= cnt[0];
                `REG_RX_BAD:    reg_rdata <= cnt[1];
                `REG_RX_DROP:   reg_rdata <= cnt[2];
                `REG_TX_FRAMES: reg_rdata <= cnt[3];
                default:        reg_rdata <= '0;
            endcase
        end
    end
end

endmodule

`default_nettype wire

// File: verilog/eth_loopback_core.sv
// Gigabit Ethernet loopback core
`timescale 1ns/10ps
`default_nettype none

`include "eth_loopback_defs.svh"

module eth_loopback_core (
    input  wire logic        clk,
    input  wire logic        rst,

    // GMII receive
    input  wire logic [7:0]  rxd,
    input  wire logic        rx_dv,
    input  wire logic        rx_er,

    // GMII transmit
    output wire logic [7:0]  txd,
    output wire logic        tx_en,
    output wire logic        tx_er,

    // Register port
    input  wire logic        reg_wr,
    input  wire logic        reg_rd,
    input  wire logic [2:0]  reg_addr,
    input  wire logic [31:0] reg_wdata,
    output wire logic [31:0] reg_rdata,

    output wire logic [1:0]  led
);

import eth_loopback_pkg::*;

wire mac_cfg_t  cfg;
wire mac_stat_t stat;
wire eth_beat_t rx_beat;
wire logic      rx_beat_wr;
wire eth_beat_t fifo_head;
wire logic      fifo_rd;
wire logic      frame_ready;

gmii_rx_framer rx_framer_inst (
    .clk(clk),
    .rst(rst),
    .rxd(rxd),
    .rx_dv(rx_dv),
    .rx_er(rx_er),
    .cfg(cfg),
    .beat(rx_beat),
    .beat_wr(rx_beat_wr),
    .stat_good(stat.rx_good),
    .stat_bad(stat.rx_bad)
);

// Holds only complete good frames
frame_fifo #(
    .entry_t(eth_beat_t),
    .DEPTH(`FIFO_DEPTH)
)
frame_fifo_inst (
    .clk(clk),
    .rst(rst),
    .wr_data(rx_beat),
    .wr_en(rx_beat_wr),
    .wr_last(rx_beat.last),
    .wr_bad(rx_beat.bad),
    .rd_data(fifo_head),
    .rd_en(fifo_rd),
    .frame_ready(frame_ready),
    .drop(stat.rx_drop)
);

gmii_tx_framer tx_framer_inst (
    .clk(clk),
    .rst(rst),
    .cfg(cfg),
    .frame_ready(frame_ready),
    .beat(fifo_head),
    .beat_rd(fifo_rd),
    .txd(txd),
    .tx_en(tx_en),
    .tx_er(tx_er),
    .stat_frame(stat.tx_frame)
);

mac_cfg_regs cfg_regs_inst (
    .clk(clk),
    .rst(rst),
    .reg_wr(reg_wr),
    .reg_rd(reg_rd),
    .reg_addr(reg_addr),
    .reg_wdata(reg_wdata),
    .reg_rdata(reg_rdata),
    .stat(stat),
    .cfg(cfg),
    .led(led)
);

endmodule

`default_nettype wire

// File: test/eth_loopback_chk.sv
// Loopback core protocol checks
`timescale 1ns/10ps
`default_nettype none

module eth_loopback_chk (
    input wire logic                       clk,
    input wire logic                       rst,
    input wire logic                       tx_en,
    input wire logic                       tx_er,
    input wire logic                       fifo_rd,
    input wire logic                       frame_ready,
    input wire eth_loopback_pkg::mac_cfg_t cfg
);

int unsigned fail_cnt = 0;
logic [8:0]  low_cnt;
logic        had_frame;

// Idle cycles since tx_en last fell, saturating
always_ff @(posedge clk) begin
    if (rst) begin
        low_cnt   <= '0;
        had_frame <= 1'b0;
    end else if (tx_en) begin
        low_cnt   <= '0;
        had_frame <= 1'b1;
    end else if (low_cnt != '1) begin
        low_cnt <= low_cnt + 9'd1;
    end
end

tx_er_low: assert property (@(posedge clk) disable iff (rst) !tx_er)
    else begin
        $error("tx_er driven high");
        fail_cnt++;
    end

// First frame after reset has no gap before it
gap_min: assert property (@(posedge clk) disable iff (rst)
    ($rose(tx_en) && had_frame) |-> (low_cnt >= {1'b0, cfg.ifg}))
    else begin
        $error("tx_en rose after %0d idle cycles, gap is %0d", low_cnt, cfg.ifg);
        fail_cnt++;
    end

// A committed frame means the FIFO holds data
rd_not_empty: assert property (@(posedge clk) disable iff (rst) fifo_rd |-> frame_ready)
    else begin
        $error("FIFO read strobe while no frame is stored");
        fail_cnt++;
    end

endmodule

bind eth_loopback_core eth_loopback_chk chk (
    .clk(clk),
    .rst(rst),
    .tx_en(tx_en),
    .tx_er(tx_er),
    .fifo_rd(fifo_rd),
    .frame_ready(frame_ready),
    .cfg(cfg)
);

`default_nettype wire

// File: test/tb_eth_loopback.sv
// Ethernet loopback testbench
`timescale 1ns/10ps
`default_nettype none

`include "eth_loopback_defs.svh"

module tb_eth_loopback;

typedef logic [7:0] byte_q_t [$];

localparam int TIMEOUT_CYCLES = 5000;

logic        clk;
logic        rst;
logic [7:0]  rxd;
logic        rx_dv;
logic        rx_er;
logic        reg_wr;
logic        reg_rd;
logic [2:0]  reg_addr;
logic [31:0] reg_wdata;
wire  [7:0]  txd;
wire         tx_en;
wire         tx_er;
wire  [31:0] reg_rdata;
wire  [1:0]  led;

int          errors;
int          frames_seen;
int          sent_good;
int          last_gap;
int          low_cycles;
logic        prev_en;
byte_q_t     cap;
byte_q_t     exp_bytes;
int          exp_len [$];
logic [31:0] base_bad;
logic [31:0] snap [4];

eth_loopback_core uut (
    .clk(clk),
    .rst(rst),
    .rxd(rxd),
    .rx_dv(rx_dv),
    .rx_er(rx_er),
    .txd(txd),
    .tx_en(tx_en),
    .tx_er(tx_er),
    .reg_wr(reg_wr),
    .reg_rd(reg_rd),
    .reg_addr(reg_addr),
    .reg_wdata(reg_wdata),
    .reg_rdata(reg_rdata),
    .led(led)
);

always #5 clk = ~clk;

// Ethernet FCS computed bit by bit over the reflected polynomial
function automatic logic [31:0] fcs_of(input byte_q_t data);
    logic [31:0] crc;
    logic        fb;
    crc = 32'hFFFFFFFF;
    foreach (data[i]) begin
        for (int b = 0; b < 8; b++) begin
            fb  = crc[0] ^ data[i][b];
            crc = {1'b0, crc[31:1]};
            if (fb) begin
                crc = crc ^ 32'hEDB88320;
            end
        end
    end
    return ~crc;
endfunction

task automatic drive_byte(input logic [7:0] b, input logic dv, input logic er);
    @(posedge clk);
    #1;
    rxd   = b;
    rx_dv = dv;
    rx_er = er;
endtask

task automatic send_frame(input int len, input bit bad_fcs, input bit raise_er,
                          input bit expect_back);
    byte_q_t     payload;
    logic [31:0] fcs;
    for (int i = 0; i < len; i++) begin
        payload.push_back(8'($urandom));
    end
    fcs = fcs_of(payload);
    if (bad_fcs) begin
        fcs = fcs ^ 32'h00000100;
    end
    if (expect_back) begin
        exp_len.push_back(len);
        foreach (payload[i]) begin
            exp_bytes.push_back(payload[i]);
        end
        sent_good++;
    end
    for (int i = 0; i < 7; i++) begin
        drive_byte(8'h55, 1'b1, 1'b0);
    end
    drive_byte(8'hD5, 1'b1, 1'b0);
    foreach (payload[i]) begin
        drive_byte(payload[i], 1'b1, raise_er && (i == 10));
    end
    for (int i = 0; i < 4; i++) begin
        drive_byte(fcs[8*i +: 8], 1'b1, 1'b0);
    end
    // Short idle gap on the receive side
    for (int i = 0; i < 4; i++) begin
        drive_byte(8'h00, 1'b0, 1'b0);
    end
endtask

task automatic write_reg(input logic [2:0] addr, input logic [31:0] value);
    @(posedge clk);
    #1;
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = value;
    @(posedge clk);
    #1;
    reg_wr = 1'b0;
endtask

task automatic read_reg(input logic [2:0] addr, output logic [31:0] value);
    @(posedge clk);
    #1;
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(posedge clk);
    #1;
    reg_rd = 1'b0;
    value  = reg_rdata;
endtask

task automatic check_reg(input logic [2:0] addr, input logic [31:0] expv, input string name);
    logic [31:0] v;
    read_reg(addr, v);
    assert (v == expv) else begin
        $display("Fail %s: got %h expected %h", name, v, expv);
        errors++;
    end
endtask

task automatic wait_all();
    int cycles;
    cycles = 0;
    while (frames_seen < sent_good && cycles < TIMEOUT_CYCLES) begin
        @(posedge clk);
        cycles++;
    end
    if (frames_seen < sent_good) begin
        $display("Timeout: only %0d of %0d frames came back on the transmit port",
                 frames_seen, sent_good);
        errors++;
    end
endtask

// Compares one captured transmit frame with the oldest expected payload
task automatic check_frame();
    int          n;
    int          len;
    int          exp_n;
    logic [7:0]  want;
    byte_q_t     data;
    logic [31:0] got;
    logic [31:0] fcs;
    frames_seen++;
    // LED toggles once per transmitted frame
    assert (led[1] == frames_seen[0]) else begin
        $display("Fail led[1]: got %h expected %h", led[1], frames_seen[0]);
        errors++;
    end
    if (exp_len.size() == 0) begin
        $display("Unexpected frame of %0d bytes on the transmit port", cap.size());
        errors++;
    end else if (cap.size() < 12) begin
        $display("Transmit frame of %0d bytes is too short for preamble and FCS", cap.size());
        void'(exp_len.pop_front());
        errors++;
    end else begin
        for (int i = 0; i < 8; i++) begin
            want = (i == 7) ? 8'hD5 : 8'h55;
            assert (cap[i] == want) else begin
                $display("Fail txd preamble[%0d]: got %h expected %h", i, cap[i], want);
                errors++;
            end
        end
        n     = cap.size() - 12;
        len   = exp_len.pop_front();
        exp_n = (len < `ETH_MIN_FRAME_LEN) ? `ETH_MIN_FRAME_LEN : len;
        assert (n == exp_n) else begin
            $display("Fail txd data length: got %h expected %h", n, exp_n);
            errors++;
        end
        data = cap[8 : 8 + n - 1];
        // Pad bytes beyond the payload must be zero
        for (int i = 0; i < n; i++) begin
            want = (i < len) ? exp_bytes[i] : 8'h00;
            assert (data[i] == want) else begin
                $display("Fail txd data[%0d]: got %h expected %h", i, data[i], want);
                errors++;
            end
        end
        for (int i = 0; i < len; i++) begin
            void'(exp_bytes.pop_front());
        end
        fcs = fcs_of(data);
        got = {cap[n + 11], cap[n + 10], cap[n + 9], cap[n + 8]};
        assert (got == fcs) else begin
            $display("Fail txd fcs: got %h expected %h", got, fcs);
            errors++;
        end
    end
    cap.delete();
endtask

// Transmit monitor
always @(posedge clk) begin
    if (rst) begin
        cap.delete();
        low_cycles = 0;
        prev_en    = 1'b0;
    end else begin
        if (tx_en) begin
            if (!prev_en) begin
                last_gap = low_cycles;
            end
            cap.push_back(txd);
            low_cycles = 0;
        end else begin
            if (prev_en) begin
                check_frame();
            end
            low_cycles++;
        end
        prev_en = tx_en;
    end
end

initial begin
    void'($urandom(32'hfff6fb12));
    clk         = 1'b0;
    rst         = 1'b1;
    rxd         = 8'h00;
    rx_dv       = 1'b0;
    rx_er       = 1'b0;
    reg_wr      = 1'b0;
    reg_rd      = 1'b0;
    reg_addr    = 3'd0;
    reg_wdata   = 32'd0;
    errors      = 0;
    frames_seen = 0;
    sent_good   = 0;
    last_gap    = 0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    // Good frame of random length
    send_frame(60 + int'($urandom % 141), 1'b0, 1'b0, 1'b1);
    wait_all();

    // Bad FCS and rx_er frames are dropped and counted
    read_reg(`REG_RX_BAD, base_bad);
    send_frame(100, 1'b1, 1'b0, 1'b0);
    send_frame(100, 1'b0, 1'b1, 1'b0);
    send_frame(80, 1'b0, 1'b0, 1'b1);
    wait_all();
    check_reg(`REG_RX_BAD, base_bad + 32'd2, "RX_BAD");

    // Runt followed by a minimum size frame
    send_frame(40, 1'b0, 1'b0, 1'b0);
    send_frame(60, 1'b0, 1'b0, 1'b1);
    wait_all();
    check_reg(`REG_RX_BAD, base_bad + 32'd3, "RX_BAD");

    // Gap of 20 between back-to-back frames
    write_reg(`REG_CFG, 32'h314);
    send_frame(80, 1'b0, 1'b0, 1'b1);
    send_frame(80, 1'b0, 1'b0, 1'b1);
    wait_all();
    assert (last_gap == 20) else begin
        $display("Fail tx_en low cycles: got %h expected %h", last_gap, 20);
        errors++;
    end

    // Receiver disabled
    write_reg(`REG_CFG, 32'h214);
    assert (led[0] == 1'b0) else begin
        $display("Fail led[0]: got %h expected %h", led[0], 1'b0);
        errors++;
    end
    check_reg(`REG_CFG, 32'h214, "CFG");
    read_reg(`REG_RX_GOOD, snap[0]);
    read_reg(`REG_RX_BAD, snap[1]);
    read_reg(`REG_RX_DROP, snap[2]);
    read_reg(`REG_TX_FRAMES, snap[3]);
    send_frame(70, 1'b0, 1'b0, 1'b0);
    send_frame(90, 1'b0, 1'b0, 1'b0);
    check_reg(`REG_RX_GOOD, snap[0], "RX_GOOD");
    check_reg(`REG_RX_BAD, snap[1], "RX_BAD");
    check_reg(`REG_RX_DROP, snap[2], "RX_DROP");
    check_reg(`REG_TX_FRAMES, snap[3], "TX_FRAMES");
    write_reg(`REG_CFG, 32'h314);
    assert (led[0] == 1'b1) else begin
        $display("Fail led[0]: got %h expected %h", led[0], 1'b1);
        errors++;
    end
    send_frame(64, 1'b0, 1'b0, 1'b1);
    wait_all();

    // Counters over a run of good frames and clear on write
    write_reg(`REG_RX_GOOD, 32'd0);
    write_reg(`REG_TX_FRAMES, 32'd0);
    for (int i = 0; i < 4; i++) begin
        send_frame(60 + int'($urandom % 141), 1'b0, 1'b0, 1'b1);
    end
    wait_all();
    check_reg(`REG_RX_GOOD, 32'd4, "RX_GOOD");
    check_reg(`REG_TX_FRAMES, 32'd4, "TX_FRAMES");
    write_reg(`REG_RX_GOOD, 32'd0);
    check_reg(`REG_RX_GOOD, 32'd0, "RX_GOOD");

    $display("Done: %0d testbench errors, %0d assertion errors", errors, uut.chk.fail_cnt);
    if (errors == 0 && uut.chk.fail_cnt == 0) begin
        $display("Test passed");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: eth_loopback.f
+incdir+verilog
verilog/eth_loopback_pkg.sv
verilog/gmii_rx_framer.sv
verilog/frame_fifo.sv
verilog/gmii_tx_framer.sv
verilog/mac_cfg_regs.sv
verilog/eth_loopback_core.sv
test/eth_loopback_chk.sv
test/tb_eth_loopback.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_eth_loopback
FILELIST = eth_loopback.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Test passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides the verdict, so a missing pass line fails the target
run: compile
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
